//--- logic/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data and address width
`define XLEN 32

// Word index width of the data memory
// 8 gives 256 words
`define DMEM_ADDR_BITS 8

// Cycles a bus request may wait for ack before it faults
`define LSU_TIMEOUT_CYCLES 16

`endif

//--- logic/lsu_op_pkg.sv
`default_nettype none

package lsu_op_pkg;

   // Load kinds
   typedef enum logic [2:0] {
      LD_OPS_NONE = 3'd0,
      LD_OPS_LB,
      LD_OPS_LBU,
      LD_OPS_LH,
      LD_OPS_LHU,
      LD_OPS_LW
   } type_ld_ops_e;

   // Store kinds
   typedef enum logic [1:0] {
      ST_OPS_NONE = 2'd0,
      ST_OPS_SB,
      ST_OPS_SH,
      ST_OPS_SW
   } type_st_ops_e;

   // Atomic kinds
   typedef enum logic [3:0] {
      AMO_OPS_NONE = 4'd0,
      AMO_OPS_LR,
      AMO_OPS_SC,
      AMO_OPS_SWAP,
      AMO_OPS_ADD,
      AMO_OPS_XOR,
      AMO_OPS_AND,
      AMO_OPS_OR,
      AMO_OPS_MIN,
      AMO_OPS_MAX,
      AMO_OPS_MINU,
      AMO_OPS_MAXU
   } type_amo_ops_e;

endpackage : lsu_op_pkg

`default_nettype wire

//--- logic/lsu_bus_pkg.sv
`default_nettype none

`include "lsu_defs.svh"

package lsu_bus_pkg;

   // One memory word seen as byte lanes or as halfword lanes
   typedef union packed {
      logic [`XLEN/8-1:0][7:0]   lane_b;
      logic [`XLEN/16-1:0][15:0] lane_h;
   } type_mem_word_u;

   // Write byte enables with one bit per byte lane
   typedef logic [`XLEN/8-1:0] type_byte_mask_t;

endpackage : lsu_bus_pkg

`default_nettype wire

//--- logic/lsu_dbus_if.sv
`default_nettype none

`include "lsu_defs.svh"

interface lsu_dbus_if import lsu_bus_pkg::*; ();

   logic [`XLEN-1:0] addr;
   logic             ld_req;
   logic             st_req;
   type_mem_word_u   w_data;
   type_byte_mask_t  w_mask;
   logic             ack;
   type_mem_word_u   r_data;

   // Request side held as a level until ack
   modport req_mp (
      output addr,
      output ld_req,
      output st_req,
      input  ack
   );

   // Data lanes in both directions
   modport data_mp (
      output w_data,
      output w_mask,
      input  r_data,
      input  ack
   );

   // Memory side
   modport mem_mp (
      input  addr,
      input  ld_req,
      input  st_req,
      input  w_data,
      input  w_mask,
      output ack,
      output r_data
   );

endinterface : lsu_dbus_if

`default_nettype wire

//--- logic/lsu_ctrl_fsm.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_ctrl_fsm import lsu_op_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             req_i,
   input  type_ld_ops_e     ld_ops_i,
   input  type_st_ops_e     st_ops_i,
   input  type_amo_ops_e    amo_ops_i,
   input  logic [`XLEN-1:0] addr_i,
   input  logic             timeout_i,
   input  logic             sc_pass_i,
   input  logic [`XLEN-1:0] ld_data_i,
   input  logic [`XLEN-1:0] old_i,
   output logic             busy_o,
   output logic             done_o,
   output logic             fault_o,
   output logic [`XLEN-1:0] rdata_o,
   output logic             phase_wr_o,
   output type_ld_ops_e     op_ld_o,
   output type_st_ops_e     op_st_o,
   output type_amo_ops_e    op_amo_o,
   lsu_dbus_if.req_mp       dbus
);

   localparam logic [1:0] S_IDLE  = 2'd0;
   localparam logic [1:0] S_READ  = 2'd1;
   localparam logic [1:0] S_WRITE = 2'd2;
   localparam logic [1:0] S_DONE  = 2'd3;

   logic [1:0]       state_q;
   logic [1:0]       state_d;
   type_ld_ops_e     ld_q;
   type_st_ops_e     st_q;
   type_amo_ops_e    amo_q;
   logic [`XLEN-1:0] addr_q;
   logic             fault_q;
   logic             sc_fail_q;
   logic             is_sc;
   logic             is_amo;
   logic             sc_fail;

   assign is_sc   = (amo_q == AMO_OPS_SC);
   assign is_amo  = (amo_q != AMO_OPS_NONE);
   // Without a valid reservation the SC ends without touching the bus
   assign sc_fail = is_sc & ~sc_pass_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: begin
            if (req_i) begin
               state_d = (st_ops_i != ST_OPS_NONE) ? S_WRITE : S_READ;
            end
         end
         S_READ: begin
            if (sc_fail || timeout_i) begin
               state_d = S_DONE;
            end else if (dbus.ack) begin
               // Atomics go on to write back the computed word
               state_d = is_amo ? S_WRITE : S_DONE;
            end
         end
         S_WRITE: begin
            if (timeout_i || dbus.ack) begin
               state_d = S_DONE;
            end
         end
         default: begin
            state_d = S_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q   <= S_IDLE;
         ld_q      <= LD_OPS_NONE;
         st_q      <= ST_OPS_NONE;
         amo_q     <= AMO_OPS_NONE;
         fault_q   <= 1'b0;
         sc_fail_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == S_IDLE && req_i) begin
            ld_q      <= ld_ops_i;
            st_q      <= st_ops_i;
            amo_q     <= amo_ops_i;
            fault_q   <= 1'b0;
            sc_fail_q <= 1'b0;
         end
         if ((state_q == S_READ || state_q == S_WRITE) && timeout_i) begin
            fault_q <= 1'b1;
         end
         if (state_q == S_READ && sc_fail) begin
            sc_fail_q <= 1'b1;
         end
      end
   end

   // Address taken together with the operation
   always_ff @(posedge clk) begin
      if (state_q == S_IDLE && req_i) begin
         addr_q <= addr_i;
      end
   end

   // Result select held until the next request
   always_comb begin
      if (fault_q) begin
         rdata_o = '0;
      end else if (ld_q != LD_OPS_NONE) begin
         rdata_o = ld_data_i;
      end else if (is_sc) begin
         rdata_o = {{(`XLEN-1){1'b0}}, sc_fail_q};
      end else if (is_amo) begin
         rdata_o = old_i;
      end else begin
         rdata_o = '0;
      end
   end

   assign busy_o      = (state_q != S_IDLE);
   assign done_o      = (state_q == S_DONE);
   assign fault_o     = fault_q;
   assign phase_wr_o  = (state_q == S_WRITE) & is_amo;
   assign op_ld_o     = ld_q;
   assign op_st_o     = st_q;
   assign op_amo_o    = amo_q;

   assign dbus.addr   = addr_q;
   assign dbus.ld_req = (state_q == S_READ) & ~sc_fail;
   assign dbus.st_req = (state_q == S_WRITE);

endmodule : lsu_ctrl_fsm

`default_nettype wire

//--- logic/bus_timeout_timer.sv
`default_nettype none

`include "lsu_defs.svh"

module bus_timeout_timer (
   input  logic clk,
   input  logic rst_n,
   input  logic dbus_wait_i,
   input  logic ack_i,
   output logic timeout_o
);

   localparam int CNT_W = $clog2(`LSU_TIMEOUT_CYCLES + 1);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`LSU_TIMEOUT_CYCLES - 1);

   logic [CNT_W-1:0] cnt_q;

   // Waiting cycles of the current request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt_q <= '0;
      end else if (!dbus_wait_i || ack_i) begin
         cnt_q <= '0;
      end else if (!timeout_o) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // Fires in the last allowed waiting cycle and the request then drops
   assign timeout_o = dbus_wait_i & ~ack_i & (cnt_q == CNT_LAST);

endmodule : bus_timeout_timer

`default_nettype wire

//--- logic/lsu_lane_align.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_lane_align import lsu_op_pkg::*, lsu_bus_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  type_ld_ops_e     op_ld_i,
   input  type_st_ops_e     op_st_i,
   input  logic             phase_wr_i,
   input  logic [`XLEN-1:0] amo_result_i,
   input  logic [`XLEN-1:0] wdata_i,
   input  logic [`XLEN-1:0] addr_i,
   output logic [`XLEN-1:0] ld_data_o,
   lsu_dbus_if.data_mp      dbus
);

   type_mem_word_u   w_word;
   type_byte_mask_t  w_mask;
   type_mem_word_u   rd_word;
   logic [7:0]       ld_byte;
   logic [15:0]      ld_half;
   logic [`XLEN-1:0] ld_ext;

   // Store data replicated into the lanes and the mask picks the written ones
   always_comb begin
      w_word = '0;
      w_mask = '0;
      if (phase_wr_i) begin
         w_word = type_mem_word_u'(amo_result_i);
         w_mask = '1;
      end else begin
         case (op_st_i)
            ST_OPS_SB: begin
               w_word.lane_b = {(`XLEN/8){wdata_i[7:0]}};
               w_mask        = type_byte_mask_t'(4'b0001 << addr_i[1:0]);
            end
            ST_OPS_SH: begin
               w_word.lane_h = {(`XLEN/16){wdata_i[15:0]}};
               w_mask        = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            ST_OPS_SW: begin
               w_word = type_mem_word_u'(wdata_i);
               w_mask = '1;
            end
            default: begin
            end
         endcase
      end
   end

   assign dbus.w_data = w_word;
   assign dbus.w_mask = w_mask;

   // Lane select on the read word
   assign rd_word = dbus.r_data;
   assign ld_byte = rd_word.lane_b[addr_i[1:0]];
   assign ld_half = rd_word.lane_h[addr_i[1]];

   always_comb begin
      case (op_ld_i)
         LD_OPS_LB:  ld_ext = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
         LD_OPS_LBU: ld_ext = {{(`XLEN-8){1'b0}}, ld_byte};
         LD_OPS_LH:  ld_ext = {{(`XLEN-16){ld_half[15]}}, ld_half};
         LD_OPS_LHU: ld_ext = {{(`XLEN-16){1'b0}}, ld_half};
         LD_OPS_LW:  ld_ext = rd_word;
         default:    ld_ext = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ld_data_o <= '0;
      end else if (dbus.ack) begin
         ld_data_o <= ld_ext;
      end
   end

endmodule : lsu_lane_align

`default_nettype wire

//--- logic/amo_unit.sv
`default_nettype none

`include "lsu_defs.svh"

module amo_unit import lsu_op_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  type_amo_ops_e    op_amo_i,
   input  logic [`XLEN-1:0] addr_i,
   input  logic [`XLEN-1:0] wdata_i,
   input  logic [`XLEN-1:0] rdata_i,
   input  logic             ack_i,
   input  logic             phase_wr_i,
   input  logic             done_i,
   output logic [`XLEN-1:0] result_o,
   output logic [`XLEN-1:0] old_o,
   output logic             sc_pass_o
);

   logic [`XLEN-1:0] old_q;
   logic [`XLEN-1:0] res_addr_q;
   logic             res_valid_q;
   logic             a_lt_b;
   logic             a_ltu_b;

   // Old word from the read half of the atomic
   always_ff @(posedge clk) begin
      if (ack_i && !phase_wr_i && op_amo_i != AMO_OPS_NONE) begin
         old_q <= rdata_i;
      end
   end

   assign a_lt_b  = $signed(old_q) < $signed(wdata_i);
   assign a_ltu_b = old_q < wdata_i;

   always_comb begin
      case (op_amo_i)
         // LR writes back what it read
         AMO_OPS_LR:   result_o = old_q;
         AMO_OPS_ADD:  result_o = old_q + wdata_i;
         AMO_OPS_XOR:  result_o = old_q ^ wdata_i;
         AMO_OPS_AND:  result_o = old_q & wdata_i;
         AMO_OPS_OR:   result_o = old_q | wdata_i;
         AMO_OPS_MIN:  result_o = a_lt_b ? old_q : wdata_i;
         AMO_OPS_MAX:  result_o = a_lt_b ? wdata_i : old_q;
         AMO_OPS_MINU: result_o = a_ltu_b ? old_q : wdata_i;
         AMO_OPS_MAXU: result_o = a_ltu_b ? wdata_i : old_q;
         default:      result_o = wdata_i;
      endcase
   end

   // Reservation set by LR and dropped by any SC
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_valid_q <= 1'b0;
      end else if (done_i) begin
         if (op_amo_i == AMO_OPS_LR) begin
            res_valid_q <= 1'b1;
         end else if (op_amo_i == AMO_OPS_SC) begin
            res_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (done_i && op_amo_i == AMO_OPS_LR) begin
         res_addr_q <= addr_i;
      end
   end

   assign old_o     = old_q;
   assign sc_pass_o = res_valid_q & (res_addr_q == addr_i);

endmodule : amo_unit

`default_nettype wire

//--- logic/data_mem.sv
`default_nettype none

`include "lsu_defs.svh"

module data_mem import lsu_bus_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   lsu_dbus_if.mem_mp  dbus
);

   localparam int DEPTH = 1 << `DMEM_ADDR_BITS;

   type_mem_word_u             mem [DEPTH];
   logic [`DMEM_ADDR_BITS-1:0] idx;
   logic                       in_range;
   logic                       access;

   assign idx      = dbus.addr[`DMEM_ADDR_BITS+1:2];
   // Upper address bits must be clear for the word to exist
   assign in_range = (dbus.addr[`XLEN-1:`DMEM_ADDR_BITS+2] == '0);
   // One access per request since the held level is ignored in the ack cycle
   assign access   = (dbus.ld_req | dbus.st_req) & in_range & ~dbus.ack;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dbus.ack <= 1'b0;
      end else begin
         dbus.ack <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         dbus.r_data <= mem[idx];
         if (dbus.st_req) begin
            for (int i = 0; i < `XLEN/8; i++) begin
               if (dbus.w_mask[i]) begin
                  mem[idx].lane_b[i] <= dbus.w_data.lane_b[i];
               end
            end
         end
      end
   end

endmodule : data_mem

`default_nettype wire

//--- logic/lsu_top.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_top import lsu_op_pkg::*; (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             req_i,
   input  type_ld_ops_e     ld_ops_i,
   input  type_st_ops_e     st_ops_i,
   input  type_amo_ops_e    amo_ops_i,
   input  logic [`XLEN-1:0] addr_i,
   input  logic [`XLEN-1:0] wdata_i,
   output logic             busy_o,
   output logic             done_o,
   output logic [`XLEN-1:0] rdata_o,
   output logic             fault_o
);

   logic             timeout;
   logic             sc_pass;
   logic             phase_wr;
   logic             done;
   type_ld_ops_e     op_ld;
   type_st_ops_e     op_st;
   type_amo_ops_e    op_amo;
   logic [`XLEN-1:0] amo_result;
   logic [`XLEN-1:0] amo_old;
   logic [`XLEN-1:0] ld_data;

   lsu_dbus_if dbus ();

   lsu_ctrl_fsm u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_i      (req_i),
      .ld_ops_i   (ld_ops_i),
      .st_ops_i   (st_ops_i),
      .amo_ops_i  (amo_ops_i),
      .addr_i     (addr_i),
      .timeout_i  (timeout),
      .sc_pass_i  (sc_pass),
      .ld_data_i  (ld_data),
      .old_i      (amo_old),
      .busy_o     (busy_o),
      .done_o     (done),
      .fault_o    (fault_o),
      .rdata_o    (rdata_o),
      .phase_wr_o (phase_wr),
      .op_ld_o    (op_ld),
      .op_st_o    (op_st),
      .op_amo_o   (op_amo),
      .dbus       (dbus.req_mp)
   );

   // Any pending read or write request
   bus_timeout_timer u_timer (
      .clk         (clk),
      .rst_n       (rst_n),
      .dbus_wait_i (dbus.ld_req | dbus.st_req),
      .ack_i       (dbus.ack),
      .timeout_o   (timeout)
   );

   // Aligner and atomic unit work on the registered bus address
   lsu_lane_align u_align (
      .clk          (clk),
      .rst_n        (rst_n),
      .op_ld_i      (op_ld),
      .op_st_i      (op_st),
      .phase_wr_i   (phase_wr),
      .amo_result_i (amo_result),
      .wdata_i      (wdata_i),
      .addr_i       (dbus.addr),
      .ld_data_o    (ld_data),
      .dbus         (dbus.data_mp)
   );

   amo_unit u_amo (
      .clk        (clk),
      .rst_n      (rst_n),
      .op_amo_i   (op_amo),
      .addr_i     (dbus.addr),
      .wdata_i    (wdata_i),
      .rdata_i    (dbus.r_data),
      .ack_i      (dbus.ack),
      .phase_wr_i (phase_wr),
      .done_i     (done),
      .result_o   (amo_result),
      .old_o      (amo_old),
      .sc_pass_o  (sc_pass)
   );

   data_mem u_mem (
      .clk   (clk),
      .rst_n (rst_n),
      .dbus  (dbus.mem_mp)
   );

   assign done_o = done;

endmodule : lsu_top

`default_nettype wire

//--- dv/lsu_tb.sv
`default_nettype none

`include "lsu_defs.svh"

module lsu_tb import lsu_op_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_OPS = 170;
   localparam int WATCHDOG_CYCLES = 8 + N_OPS * (`LSU_TIMEOUT_CYCLES + 10);
   localparam int WORDS = 8;
   localparam logic [31:0] BAD_ADDR = 32'h1 << (`DMEM_ADDR_BITS + 2);

   logic          clk;
   logic          rst_n;
   logic          req_i;
   type_ld_ops_e  ld_ops_i;
   type_st_ops_e  st_ops_i;
   type_amo_ops_e amo_ops_i;
   logic [31:0]   addr_i;
   logic [31:0]   wdata_i;
   logic          busy_o;
   logic          done_o;
   logic [31:0]   rdata_o;
   logic          fault_o;

   logic [31:0]   exp_rdata;
   logic          exp_fault;
   int            exp_lat;
   int            lat_cnt;
   logic          pending;
   logic          rst_seen;
   int            fail_cnt;
   int            tests_done;
   logic [31:0]   seed;
   logic [31:0]   shadow [WORDS];

   lsu_top dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_i     (req_i),
      .ld_ops_i  (ld_ops_i),
      .st_ops_i  (st_ops_i),
      .amo_ops_i (amo_ops_i),
      .addr_i    (addr_i),
      .wdata_i   (wdata_i),
      .busy_o    (busy_o),
      .done_o    (done_o),
      .rdata_o   (rdata_o),
      .fault_o   (fault_o)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // Cycles since the edge that took the request
   always @(posedge clk) begin
      rst_seen <= !rst_n;
      if (!rst_n) begin
         lat_cnt <= 0;
         pending <= 1'b0;
      end else if (req_i && !busy_o) begin
         lat_cnt <= 1;
         pending <= 1'b1;
      end else begin
         if (busy_o) begin
            lat_cnt <= lat_cnt + 1;
         end
         if (done_o) begin
            pending <= 1'b0;
         end
      end
   end

   reset_idle: assert property (@(posedge clk) rst_seen |-> !busy_o && !done_o && !fault_o)
      else begin
         fail_cnt++;
         $display("Outputs not idle after reset at %0t", $time);
      end
   done_needs_req: assert property (@(posedge clk) disable iff (!rst_n) !pending |-> !done_o)
      else begin
         fail_cnt++;
         $display("done_o raised without a request at %0t", $time);
      end
   busy_held: assert property (@(posedge clk) disable iff (!rst_n)
                               busy_o && !done_o |=> busy_o)
      else begin
         fail_cnt++;
         $display("busy_o dropped before done_o at %0t", $time);
      end
   rdata_check: assert property (@(posedge clk) disable iff (!rst_n)
                                 done_o |-> rdata_o == exp_rdata)
      else begin
         fail_cnt++;
         $display("FAILED t=%0t rdata_o expected %h actual %h",
                  $time, $sampled(exp_rdata), $sampled(rdata_o));
      end
   fault_check: assert property (@(posedge clk) disable iff (!rst_n)
                                 done_o |-> fault_o == exp_fault)
      else begin
         fail_cnt++;
         $display("FAILED t=%0t fault_o expected %b actual %b",
                  $time, $sampled(exp_fault), $sampled(fault_o));
      end
   latency_check: assert property (@(posedge clk) disable iff (!rst_n)
                                   done_o && exp_lat != 0 |-> lat_cnt == exp_lat)
      else begin
         fail_cnt++;
         $display("FAILED t=%0t latency expected %0d actual %0d",
                  $time, $sampled(exp_lat), $sampled(lat_cnt));
      end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic logic [31:0] load_value(type_ld_ops_e k, logic [31:0] w, logic [1:0] off);
      logic [7:0]  b;
      logic [15:0] h;
      b = w[8*off +: 8];
      h = w[16*off[1] +: 16];
      case (k)
         LD_OPS_LB:  return {{24{b[7]}}, b};
         LD_OPS_LBU: return {24'h0, b};
         LD_OPS_LH:  return {{16{h[15]}}, h};
         LD_OPS_LHU: return {16'h0, h};
         default:    return w;
      endcase
   endfunction

   function automatic logic [31:0] amo_value(type_amo_ops_e op, logic [31:0] a, logic [31:0] b);
      case (op)
         AMO_OPS_ADD:  return a + b;
         AMO_OPS_XOR:  return a ^ b;
         AMO_OPS_AND:  return a & b;
         AMO_OPS_OR:   return a | b;
         AMO_OPS_MIN:  return ($signed(a) < $signed(b)) ? a : b;
         AMO_OPS_MAX:  return ($signed(a) < $signed(b)) ? b : a;
         AMO_OPS_MINU: return (a < b) ? a : b;
         AMO_OPS_MAXU: return (a < b) ? b : a;
         default:      return b;
      endcase
   endfunction

   // Issues one request and waits for done_o while wdata_i stays until the next one
   task automatic run_op(input type_ld_ops_e ld, input type_st_ops_e st,
                         input type_amo_ops_e amo, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [31:0] expd,
                         input int lat, input logic flt);
      @(posedge clk);
      req_i     <= 1'b1;
      ld_ops_i  <= ld;
      st_ops_i  <= st;
      amo_ops_i <= amo;
      addr_i    <= addr;
      wdata_i   <= wdata;
      exp_rdata <= expd;
      exp_lat   <= lat;
      exp_fault <= flt;
      @(posedge clk);
      req_i     <= 1'b0;
      ld_ops_i  <= LD_OPS_NONE;
      st_ops_i  <= ST_OPS_NONE;
      amo_ops_i <= AMO_OPS_NONE;
      do @(negedge clk); while (!done_o);
   endtask

   task automatic store_model(input type_st_ops_e st, input logic [31:0] addr,
                              input logic [31:0] d);
      case (st)
         ST_OPS_SB: shadow[addr[4:2]][8*addr[1:0] +: 8] = d[7:0];
         ST_OPS_SH: shadow[addr[4:2]][16*addr[1] +: 16] = d[15:0];
         default:   shadow[addr[4:2]] = d;
      endcase
   endtask

   task automatic report_test(input string name, input int errs_before);
      // Lets the checks on the last done_o of the test complete
      @(negedge clk);
      tests_done++;
      $display("Test %0d %s: %0d errors", tests_done, name, fail_cnt - errs_before);
   endtask

   initial begin
      type_amo_ops_e amo_list [9];
      type_st_ops_e  st;
      logic [31:0]   r;
      logic [31:0]   a;
      logic [31:0]   b;
      logic [31:0]   adr;
      int            errs;
      amo_list = '{AMO_OPS_SWAP, AMO_OPS_ADD, AMO_OPS_XOR, AMO_OPS_AND, AMO_OPS_OR,
                   AMO_OPS_MIN, AMO_OPS_MAX, AMO_OPS_MINU, AMO_OPS_MAXU};
      seed = 32'h0dbf_9d9d;
      fail_cnt = 0;
      tests_done = 0;
      rst_n = 1'b0;
      req_i = 1'b0;
      ld_ops_i = LD_OPS_NONE;
      st_ops_i = ST_OPS_NONE;
      amo_ops_i = AMO_OPS_NONE;
      addr_i = '0;
      wdata_i = '0;
      exp_rdata = '0;
      exp_fault = 1'b0;
      exp_lat = 0;
      a = '0;

      errs = fail_cnt;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      repeat (4) @(posedge clk);
      report_test("reset", errs);

      errs = fail_cnt;
      for (int w = 0; w < WORDS; w++) begin
         r = next_rand();
         run_op(LD_OPS_NONE, ST_OPS_SW, AMO_OPS_NONE, 32'(w * 4), r, 32'h0, 3, 1'b0);
         store_model(ST_OPS_SW, 32'(w * 4), r);
      end
      for (int i = 0; i < 16; i++) begin
         r = next_rand();
         case (r[9:8])
            2'd2: st = ST_OPS_SH;
            2'd3: st = ST_OPS_SW;
            default: st = ST_OPS_SB;
         endcase
         adr = {27'h0, r[4:0]};
         adr = (st == ST_OPS_SH) ? (adr & ~32'h1) : (st == ST_OPS_SW) ? (adr & ~32'h3) : adr;
         b = next_rand();
         run_op(LD_OPS_NONE, st, AMO_OPS_NONE, adr, b, 32'h0, 3, 1'b0);
         store_model(st, adr, b);
      end
      for (int w = 0; w < WORDS; w++) begin
         for (int l = 0; l < 4; l++) begin
            adr = 32'(w * 4 + l);
            run_op(LD_OPS_LB, ST_OPS_NONE, AMO_OPS_NONE, adr, 32'h0,
                   load_value(LD_OPS_LB, shadow[w], adr[1:0]), 3, 1'b0);
            run_op(LD_OPS_LBU, ST_OPS_NONE, AMO_OPS_NONE, adr, 32'h0,
                   load_value(LD_OPS_LBU, shadow[w], adr[1:0]), 3, 1'b0);
            if (l % 2 == 0) begin
               run_op(LD_OPS_LH, ST_OPS_NONE, AMO_OPS_NONE, adr, 32'h0,
                      load_value(LD_OPS_LH, shadow[w], adr[1:0]), 3, 1'b0);
               run_op(LD_OPS_LHU, ST_OPS_NONE, AMO_OPS_NONE, adr, 32'h0,
                      load_value(LD_OPS_LHU, shadow[w], adr[1:0]), 3, 1'b0);
            end
            if (l == 0) begin
               run_op(LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, adr, 32'h0, shadow[w], 3, 1'b0);
            end
         end
      end
      report_test("stores and loads", errs);

      // Atomics on word 16
      errs = fail_cnt;
      foreach (amo_list[i]) begin
         a = next_rand();
         b = next_rand();
         run_op(LD_OPS_NONE, ST_OPS_SW, AMO_OPS_NONE, 32'h40, a, 32'h0, 3, 1'b0);
         run_op(LD_OPS_NONE, ST_OPS_NONE, amo_list[i], 32'h40, b, a, 5, 1'b0);
         a = amo_value(amo_list[i], a, b);
         run_op(LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, 32'h40, 32'h0, a, 3, 1'b0);
      end
      report_test("atomics", errs);

      errs = fail_cnt;
      r = next_rand();
      b = next_rand();
      run_op(LD_OPS_NONE, ST_OPS_SW, AMO_OPS_NONE, 32'h60, r, 32'h0, 3, 1'b0);
      run_op(LD_OPS_NONE, ST_OPS_SW, AMO_OPS_NONE, 32'h64, b, 32'h0, 3, 1'b0);
      run_op(LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_SC, 32'h60, 32'h1234, 32'h1, 2, 1'b0);
      run_op(LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_LR, 32'h60, 32'h0, r, 5, 1'b0);
      run_op(LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_SC, 32'h60, ~r, 32'h0, 5, 1'b0);
      run_op(LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, 32'h60, 32'h0, ~r, 3, 1'b0);
      run_op(LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_SC, 32'h60, r, 32'h1, 2, 1'b0);
      run_op(LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, 32'h60, 32'h0, ~r, 3, 1'b0);
      run_op(LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_LR, 32'h60, 32'h0, ~r, 5, 1'b0);
      run_op(LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_SC, 32'h64, r, 32'h1, 2, 1'b0);
      run_op(LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, 32'h64, 32'h0, b, 3, 1'b0);
      run_op(LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_SC, 32'h60, r, 32'h1, 2, 1'b0);
      report_test("lr/sc", errs);

      errs = fail_cnt;
      run_op(LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, BAD_ADDR, 32'h0, 32'h0, 0, 1'b1);
      run_op(LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_ADD, BAD_ADDR, 32'h5, 32'h0, 0, 1'b1);
      run_op(LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, 32'h40, 32'h0, a, 3, 1'b0);
      report_test("timeout", errs);

      repeat (2) @(posedge clk);
      $display("%0d tests run, %0d errors", tests_done, fail_cnt);
      if (fail_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * 10);
      $display("Watchdog expired before the tests finished");
      $display("Test failures found");
      $finish;
   end

endmodule : lsu_tb

`default_nettype wire

//--- lsu_amo.f
+incdir+logic
logic/lsu_op_pkg.sv
logic/lsu_bus_pkg.sv
logic/lsu_dbus_if.sv
logic/lsu_ctrl_fsm.sv
logic/bus_timeout_timer.sv
logic/lsu_lane_align.sv
logic/amo_unit.sv
logic/data_mem.sv
logic/lsu_top.sv
dv/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the lsu_amo testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lsu_tb \
   -f lsu_amo.f -o lsu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
   cat sim.log
   echo "Simulation exited with an error status"
   exit 1
fi

cat sim.log
if grep -q "^All tests passed!$" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1
